/* compile.f */
logic/ps2_pkg.sv
logic/ps2_us_timer.sv
logic/ps2_line_sync.sv
logic/ps2_frame_shift.sv
logic/ps2_send_fsm.sv
logic/ps2_host_tx.sv
testbench/tb_clock_gen.sv
testbench/ps2_host_tx_tb.sv

/* Makefile */
TOP = ps2_host_tx_tb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module $(TOP) -o $(TOP) -f compile.f

run: compile
	./obj_dir/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Testbench failed" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* testbench/ps2_host_tx_tb.sv */
// PS/2 host transmitter testbench

`timescale 1ns/10ps

module ps2_host_tx_tb;

	//////////////////////////////////////////////////
	// timing and test sizes
	//////////////////////////////////////////////////

	localparam int CYC_PER_US = int'(ps2_pkg::CYCLES_PER_US);
	localparam int NBITS = int'(ps2_pkg::FRAME_BITS);

	// 20 us per half of the 40 us device clock
	localparam int HALF_CYC = 20 * CYC_PER_US;
	// delay from request to send until the first device fall
	localparam int DEV_LEAD_CYC = 10 * CYC_PER_US;
	// ack goes out this long after the stop bit rise
	localparam int ACK_LEAD_CYC = 5 * CYC_PER_US;

	localparam int INH_CYC = int'(ps2_pkg::INHIBIT_US) * CYC_PER_US;
	localparam int OK_WAIT_CYC = (int'(ps2_pkg::DEVICE_TIMEOUT_US) + 500) * CYC_PER_US;

	localparam real US_NS = 1000.0;
	localparam real INH_NS = real'(ps2_pkg::INHIBIT_US) * US_NS;
	localparam real TIMEOUT_NS = real'(ps2_pkg::DEVICE_TIMEOUT_US) * US_NS;

	localparam int RANDOM_FRAMES = 20;
	localparam int NACK_FRAMES = 6;
	localparam int BUSY_FRAMES = 3;
	localparam int BUSY_PULSES = 3;
	localparam int TOTAL_FRAMES = 1 + RANDOM_FRAMES + NACK_FRAMES + 1 + BUSY_FRAMES;

	// 1.5 ms per frame plus 3 ms of slack
	localparam real WATCHDOG_NS = real'(TOTAL_FRAMES) * 1.5e6 + 3.0e6;

	// which DUT output a wait watches
	localparam int SEL_CLK_LOW = 0;
	localparam int SEL_DATA_LOW = 1;
	localparam int SEL_OK = 2;

	//////////////////////////////////////////////////
	// DUT and bus
	//////////////////////////////////////////////////

	logic qzt_clk;
	logic reset;
	logic send;
	ps2_pkg::ps2_byte_t data;
	logic ps2_clk_in;
	logic ps2_data_in;
	logic ps2_clk_low;
	logic ps2_data_low;
	logic busy;
	logic ok;
	logic err;

	// device side pull-lows
	logic dev_clk_low;
	logic dev_data_low;
	logic dev_nack;
	logic dev_silent;

	// frames as the device read them
	ps2_pkg::ps2_frame_t frame_q[$];
	int dev_count;

	int ok_count = 0;
	int errors;
	int checks;
	int test_num;
	int test_checks0;
	int test_errors0;
	logic last_err;

	tb_clock_gen i_clock_gen (
		.qzt_clk (qzt_clk),
		.reset   (reset)
	);

	ps2_host_tx i_ps2_host_tx (
		.qzt_clk      (qzt_clk),
		.reset        (reset),
		.send         (send),
		.data         (data),
		.ps2_clk_in   (ps2_clk_in),
		.ps2_data_in  (ps2_data_in),
		.ps2_clk_low  (ps2_clk_low),
		.ps2_data_low (ps2_data_low),
		.busy         (busy),
		.ok           (ok),
		.err          (err)
	);

	// open-drain lines as the wired-AND of both ends
	assign ps2_clk_in  = ~(ps2_clk_low | dev_clk_low);
	assign ps2_data_in = ~(ps2_data_low | dev_data_low);

	// count ok pulses
	always @(negedge qzt_clk) begin
		if (!reset && ok) begin
			ok_count++;
		end
	end

	//////////////////////////////////////////////////
	// checks and bookkeeping
	//////////////////////////////////////////////////

	task automatic check_value(input string name, input int expected, input int actual);
		checks++;
		assert (expected == actual) else begin
			errors++;
			$display("[FAIL] time %0t: %s expected 0x%0h, got 0x%0h",
				$realtime, name, expected, actual);
		end
	endtask

	task automatic check_near(input string name, input real expected_ns,
			input real actual_ns, input real tol_ns);
		checks++;
		assert (actual_ns >= expected_ns - tol_ns && actual_ns <= expected_ns + tol_ns) else begin
			errors++;
			$display("[FAIL] time %0t: %s expected %0.1f ns (+/- %0.1f), got %0.1f ns",
				$realtime, name, expected_ns, tol_ns, actual_ns);
		end
	endtask

	function automatic logic watched_value(input int sel);
		case (sel)
			SEL_CLK_LOW: return ps2_clk_low;
			SEL_DATA_LOW: return ps2_data_low;
			SEL_OK: return ok;
			default: return 1'b0;
		endcase
	endfunction

	// poll on falling edges until the output reaches a level
	task automatic wait_for(input int sel, input logic level, input int max_cycles,
			input string what, output bit seen);
		int n;
		seen = 1'b0;
		n = 0;
		while (!seen && n < max_cycles) begin
			@(negedge qzt_clk);
			if (watched_value(sel) == level) begin
				seen = 1'b1;
			end
			n++;
		end
		checks++;
		assert (seen) else begin
			errors++;
			$display("time %0t: gave up waiting for %s after %0d cycles",
				$realtime, what, max_cycles);
		end
	endtask

	task automatic start_test();
		test_checks0 = checks;
		test_errors0 = errors;
	endtask

	task automatic finish_test(input string name);
		test_num++;
		$display("test %0d %s: %0d checks, %0d errors", test_num, name,
			checks - test_checks0, errors - test_errors0);
	endtask

	//////////////////////////////////////////////////
	// reference frame
	//////////////////////////////////////////////////

	// start 0, data lsb first, odd parity, stop 1
	function automatic ps2_pkg::ps2_frame_t expected_frame(input ps2_pkg::ps2_byte_t b);
		ps2_pkg::ps2_frame_t f;
		int ones;
		ones = 0;
		f[0] = 1'b0;
		for (int i = 0; i < 8; i++) begin
			f[i + 1] = b[i];
			if (b[i]) begin
				ones++;
			end
		end
		// even count in the byte needs a 1 here
		f[9] = (ones % 2 == 0);
		f[10] = 1'b1;
		return f;
	endfunction

	//////////////////////////////////////////////////
	// device model
	//////////////////////////////////////////////////

	// one frame of device clocking with reads on rises and the ack before the last fall
	task automatic clock_frame();
		ps2_pkg::ps2_frame_t bits;
		bits = '0;
		// start bit is the low data of the request to send
		bits[0] = ps2_data_in;
		repeat (DEV_LEAD_CYC) @(negedge qzt_clk);
		for (int k = 1; k <= NBITS; k++) begin
			dev_clk_low = 1'b1;
			repeat (HALF_CYC) @(negedge qzt_clk);
			// host moved data on the fall so read it as the clock goes up
			if (k < NBITS) begin
				bits[k] = ps2_data_in;
			end
			dev_clk_low = 1'b0;
			if (k == NBITS - 1) begin
				// after the stop bit the host lets go and the ack pulls low unless nack
				repeat (ACK_LEAD_CYC) @(negedge qzt_clk);
				dev_data_low = ~dev_nack;
				repeat (HALF_CYC - ACK_LEAD_CYC) @(negedge qzt_clk);
			end else if (k == NBITS) begin
				dev_data_low = 1'b0;
			end else begin
				repeat (HALF_CYC) @(negedge qzt_clk);
			end
		end
		frame_q.push_back(bits);
		dev_count++;
	endtask

	initial begin : device_model
		dev_clk_low  = 1'b0;
		dev_data_low = 1'b0;
		dev_count    = 0;
		forever begin
			@(negedge qzt_clk);
			// request to send is a released clock with data low
			if (!reset && ps2_clk_in && !ps2_data_in) begin
				if (dev_silent) begin
					while (!ps2_data_in) begin
						@(negedge qzt_clk);
					end
				end else begin
					clock_frame();
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// one send from the user side
	//////////////////////////////////////////////////

	task automatic run_frame(input ps2_pkg::ps2_byte_t b, input logic nack,
			input logic silent, input int pulses);
		realtime t_send;
		realtime t_clk;
		realtime t_data;
		realtime t_rel;
		realtime t_ok;
		int frames_before;
		int oks_before;
		bit seen;
		logic exp_err;
		ps2_pkg::ps2_frame_t got;

		exp_err = nack | silent;
		dev_nack = nack;
		dev_silent = silent;
		repeat ($urandom_range(2500, 50)) @(negedge qzt_clk);
		// err still held from the last frame
		check_value("err", int'(last_err), int'(err));
		frames_before = dev_count;
		oks_before = ok_count;

		data = b;
		send = 1'b1;
		t_send = $realtime;
		wait_for(SEL_CLK_LOW, 1'b1, 10, "ps2_clk_low to rise after send", seen);
		send = 1'b0;
		if (!seen) begin
			return;
		end
		t_clk = $realtime;
		check_value("ps2_data_low", 0, int'(ps2_data_low));

		// data goes low one inhibit time after the clock
		wait_for(SEL_DATA_LOW, 1'b1, INH_CYC + 500, "ps2_data_low to rise", seen);
		if (!seen) begin
			return;
		end
		t_data = $realtime;
		check_value("ps2_clk_low", 1, int'(ps2_clk_low));
		check_near("ps2_data_low rise after ps2_clk_low", INH_NS, t_data - t_clk, US_NS);

		wait_for(SEL_CLK_LOW, 1'b0, INH_CYC + 500, "ps2_clk_low to fall", seen);
		if (!seen) begin
			return;
		end
		t_rel = $realtime;
		check_near("ps2_clk_low release after ps2_data_low", INH_NS, t_rel - t_data, US_NS);

		// extra sends while busy with the last one left high
		for (int p = 0; p < pulses; p++) begin
			repeat ($urandom_range(3000, 500)) @(negedge qzt_clk);
			check_value("busy", 1, int'(busy));
			send = 1'b1;
			if (p < pulses - 1) begin
				@(negedge qzt_clk);
				send = 1'b0;
			end
		end

		wait_for(SEL_OK, 1'b1, OK_WAIT_CYC, "ok at the end of the frame", seen);
		if (!seen) begin
			send = 1'b0;
			return;
		end
		t_ok = $realtime;
		check_value("busy", 0, int'(busy));
		check_value("err", int'(exp_err), int'(err));
		check_value("ps2_clk_low", 0, int'(ps2_clk_low));
		check_value("ps2_data_low", 0, int'(ps2_data_low));
		if (silent) begin
			check_near("ok after send", TIMEOUT_NS + 2.0 * INH_NS, t_ok - t_send, US_NS);
		end

		// a held send must not start another frame
		repeat (100) @(negedge qzt_clk);
		send = 1'b0;
		repeat (100) @(negedge qzt_clk);
		check_value("busy", 0, int'(busy));
		check_value("ok pulses", 1, ok_count - oks_before);
		check_value("device frames", silent ? 0 : 1, dev_count - frames_before);
		if (frame_q.size() != 0) begin
			got = frame_q.pop_front();
			check_value("device frame", int'(expected_frame(b)), int'(got));
		end
		last_err = exp_err;
	endtask

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////

	initial begin : main
		logic nack;

		send = 1'b0;
		data = '0;
		dev_nack = 1'b0;
		dev_silent = 1'b0;
		errors = 0;
		checks = 0;
		test_num = 0;
		last_err = 1'b0;
		void'($urandom(32'hbb18_ced7));

		@(negedge qzt_clk);
		while (reset) begin
			@(negedge qzt_clk);
		end

		// outputs quiet out of reset
		start_test();
		for (int i = 0; i < 4; i++) begin
			repeat (50) @(negedge qzt_clk);
			check_value("busy", 0, int'(busy));
			check_value("ok", 0, int'(ok));
			check_value("err", 0, int'(err));
			check_value("ps2_clk_low", 0, int'(ps2_clk_low));
			check_value("ps2_data_low", 0, int'(ps2_data_low));
		end
		finish_test("reset values");

		start_test();
		run_frame(8'($urandom_range(255, 0)), 1'b0, 1'b0, 0);
		finish_test("request to send timing");

		start_test();
		for (int i = 0; i < RANDOM_FRAMES; i++) begin
			run_frame(8'($urandom_range(255, 0)), 1'b0, 1'b0, 0);
		end
		finish_test("random frames");

		// nack on the first frame and a good one next with the rest at random
		start_test();
		for (int i = 0; i < NACK_FRAMES; i++) begin
			if (i < 2) begin
				nack = (i == 0);
			end else begin
				nack = 1'($urandom_range(1, 0));
			end
			run_frame(8'($urandom_range(255, 0)), nack, 1'b0, 0);
		end
		finish_test("nack frames");

		start_test();
		run_frame(8'($urandom_range(255, 0)), 1'b0, 1'b1, 0);
		finish_test("silent device");

		start_test();
		for (int i = 0; i < BUSY_FRAMES; i++) begin
			run_frame(8'($urandom_range(255, 0)), 1'b0, 1'b0, BUSY_PULSES);
		end
		finish_test("send while busy");

		$display("tests: %0d, checks: %0d, errors: %0d", test_num, checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// stop a run that hangs
	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("watchdog: run did not finish within %0.1f ms", WATCHDOG_NS / 1.0e6);
		$display("Testbench failed");
		$finish;
	end

endmodule

/* testbench/tb_clock_gen.sv */
// Testbench clock and reset

`timescale 1ns/10ps

module tb_clock_gen (
	output logic qzt_clk,
	output logic reset
);

	// 4 ns period
	localparam real HALF_PERIOD_NS = 2.0;
	localparam int RESET_CYCLES = 8;

	initial begin
		qzt_clk = 1'b0;
		forever #(HALF_PERIOD_NS) qzt_clk = ~qzt_clk;
	end

	// reset held over 8 rising edges, dropped on a falling edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge qzt_clk);
		@(negedge qzt_clk);
		reset = 1'b0;
	end

endmodule

/* logic/ps2_host_tx.sv */
// PS/2 host transmitter top

`timescale 1ns/10ps

module ps2_host_tx (
	input  logic               qzt_clk,
	input  logic               reset,
	input  logic               send,
	input  ps2_pkg::ps2_byte_t data,
	input  logic               ps2_clk_in,
	input  logic               ps2_data_in,
	output logic               ps2_clk_low,
	output logic               ps2_data_low,
	output logic               busy,
	output logic               ok,
	output logic               err
);

	// synced line side
	logic clk_level;
	logic data_level;
	logic clk_fall;
	logic clk_rise;

	// shared delay timer
	logic               timer_start;
	logic               timer_cancel;
	ps2_pkg::us_count_t timer_us;
	logic               timer_done;

	// frame shifter
	logic frame_load;
	logic frame_shift;
	logic bit_out;
	logic last_bit;

	//////////////////////////////////////////////////
	// line input
	//////////////////////////////////////////////////

	ps2_line_sync i_line_sync (
		.qzt_clk     (qzt_clk),
		.reset       (reset),
		.ps2_clk_in  (ps2_clk_in),
		.ps2_data_in (ps2_data_in),
		.clk_level   (clk_level),
		.data_level  (data_level),
		.clk_fall    (clk_fall),
		.clk_rise    (clk_rise)
	);

	// one timer covers inhibit, hold, end of packet, release and timeout
	ps2_us_timer i_us_timer (
		.qzt_clk      (qzt_clk),
		.reset        (reset),
		.timer_start  (timer_start),
		.timer_cancel (timer_cancel),
		.timer_us     (timer_us),
		.timer_done   (timer_done)
	);

	// byte goes straight in, captured on frame_load
	ps2_frame_shift i_frame_shift (
		.qzt_clk     (qzt_clk),
		.reset       (reset),
		.frame_load  (frame_load),
		.frame_byte  (data),
		.frame_shift (frame_shift),
		.bit_out     (bit_out),
		.last_bit    (last_bit)
	);

	//////////////////////////////////////////////////
	// sequencer
	//////////////////////////////////////////////////

	ps2_send_fsm i_send_fsm (
		.qzt_clk      (qzt_clk),
		.reset        (reset),
		.send         (send),
		.clk_level    (clk_level),
		.data_level   (data_level),
		.clk_fall     (clk_fall),
		.clk_rise     (clk_rise),
		.last_bit     (last_bit),
		.bit_out      (bit_out),
		.timer_done   (timer_done),
		.frame_load   (frame_load),
		.frame_shift  (frame_shift),
		.timer_start  (timer_start),
		.timer_cancel (timer_cancel),
		.timer_us     (timer_us),
		.ps2_clk_low  (ps2_clk_low),
		.ps2_data_low (ps2_data_low),
		.busy         (busy),
		.ok           (ok),
		.err          (err)
	);

endmodule

/* logic/ps2_send_fsm.sv */
// PS/2 host send sequencer

`timescale 1ns/10ps

module ps2_send_fsm (
	input  logic               qzt_clk,
	input  logic               reset,
	input  logic               send,
	input  logic               clk_level,
	input  logic               data_level,
	input  logic               clk_fall,
	input  logic               clk_rise,
	input  logic               last_bit,
	input  logic               bit_out,
	input  logic               timer_done,
	output logic               frame_load,
	output logic               frame_shift,
	output logic               timer_start,
	output logic               timer_cancel,
	output ps2_pkg::us_count_t timer_us,
	output logic               ps2_clk_low,
	output logic               ps2_data_low,
	output logic               busy,
	output logic               ok,
	output logic               err
);

	ps2_pkg::tx_state_t state;
	ps2_pkg::tx_state_t state_next;

	// send from the previous cycle, for the rising edge
	logic send_q;
	logic send_rise;

	// host owns the data line from request to send until the stop bit hold ends
	logic data_drive;
	logic data_drive_next;

	// set once both lines are high and the release timer runs
	logic release_armed;
	logic release_armed_next;

	logic clk_low_next;
	logic busy_next;
	logic ok_next;
	logic err_next;

	// device went silent in an edge wait
	logic timeout;

	logic lines_high;

	assign send_rise  = send & ~send_q;
	assign lines_high = clk_level & data_level;

	// pull data low while driving a 0 bit, start bit included
	assign ps2_data_low = data_drive & ~bit_out;

	//////////////////////////////////////////////////
	// next state and strobes
	//////////////////////////////////////////////////

	always_comb begin
		state_next         = state;
		clk_low_next       = ps2_clk_low;
		data_drive_next    = data_drive;
		release_armed_next = release_armed;
		busy_next          = busy;
		err_next           = err;
		ok_next            = 1'b0;
		frame_load         = 1'b0;
		frame_shift        = 1'b0;
		timer_start        = 1'b0;
		timer_cancel       = 1'b0;
		timer_us           = ps2_pkg::DEVICE_TIMEOUT_US;
		timeout            = 1'b0;

		case (state)
			ps2_pkg::IDLE: begin
				// sends while busy never get here, edge is long gone
				if (send_rise) begin
					frame_load   = 1'b1;
					timer_start  = 1'b1;
					timer_us     = ps2_pkg::INHIBIT_US;
					clk_low_next = 1'b1;
					busy_next    = 1'b1;
					err_next     = 1'b0;
					state_next   = ps2_pkg::INHIBIT_CLK;
				end
			end
			ps2_pkg::INHIBIT_CLK: begin
				// clock low long enough, now data low as well
				if (timer_done) begin
					data_drive_next = 1'b1;
					timer_start     = 1'b1;
					timer_us        = ps2_pkg::INHIBIT_US;
					state_next      = ps2_pkg::INHIBIT_DATA;
				end
			end
			ps2_pkg::INHIBIT_DATA: begin
				// let the clock go, device takes over clocking
				if (timer_done) begin
					clk_low_next = 1'b0;
					timer_start  = 1'b1;
					state_next   = ps2_pkg::WAIT_FALL;
				end
			end
			ps2_pkg::WAIT_FALL: begin
				if (timer_done) begin
					timeout = 1'b1;
				end else if (last_bit) begin
					// stop bit is out, timeout keeps running from the last fall
					state_next = ps2_pkg::WAIT_LAST_RISE;
				end else if (clk_fall) begin
					// next bit on the line, timeout restarted
					frame_shift = 1'b1;
					timer_start = 1'b1;
				end
			end
			ps2_pkg::WAIT_LAST_RISE: begin
				if (timer_done) begin
					timeout = 1'b1;
				end else if (clk_rise) begin
					timer_start = 1'b1;
					timer_us    = ps2_pkg::LAST_HOLD_US;
					state_next  = ps2_pkg::HOLD_LAST;
				end
			end
			ps2_pkg::HOLD_LAST: begin
				// release data so the device can acknowledge
				if (timer_done) begin
					data_drive_next = 1'b0;
					timer_start     = 1'b1;
					state_next      = ps2_pkg::WAIT_ACK;
				end
			end
			ps2_pkg::WAIT_ACK: begin
				if (timer_done) begin
					timeout = 1'b1;
				end else if (clk_fall) begin
					// ack is a low data line, high means nack
					err_next    = data_level;
					timer_start = 1'b1;
					timer_us    = ps2_pkg::END_PACKET_US;
					state_next  = ps2_pkg::END_PACKET;
				end
			end
			ps2_pkg::END_PACKET: begin
				// device may still clock a little after the ack
				if (timer_done) begin
					release_armed_next = 1'b0;
					state_next         = ps2_pkg::WAIT_RELEASE;
				end
			end
			ps2_pkg::WAIT_RELEASE: begin
				if (!lines_high) begin
					// a low line breaks the high stretch, start over
					timer_cancel       = 1'b1;
					release_armed_next = 1'b0;
				end else if (!release_armed) begin
					timer_start        = 1'b1;
					timer_us           = ps2_pkg::RELEASE_US;
					release_armed_next = 1'b1;
				end else if (timer_done) begin
					ok_next    = 1'b1;
					busy_next  = 1'b0;
					state_next = ps2_pkg::IDLE;
				end
			end
			default: begin
				state_next = ps2_pkg::IDLE;
			end
		endcase

		// silent device, free both lines and report
		if (timeout) begin
			clk_low_next    = 1'b0;
			data_drive_next = 1'b0;
			err_next        = 1'b1;
			ok_next         = 1'b1;
			busy_next       = 1'b0;
			state_next      = ps2_pkg::IDLE;
		end
	end

	//////////////////////////////////////////////////
	// registers
	//////////////////////////////////////////////////

	always_ff @(posedge qzt_clk) begin
		if (reset) begin
			state         <= ps2_pkg::IDLE;
			send_q        <= 1'b0;
			ps2_clk_low   <= 1'b0;
			data_drive    <= 1'b0;
			release_armed <= 1'b0;
			busy          <= 1'b0;
			ok            <= 1'b0;
			err           <= 1'b0;
		end else begin
			state         <= state_next;
			send_q        <= send;
			ps2_clk_low   <= clk_low_next;
			data_drive    <= data_drive_next;
			release_armed <= release_armed_next;
			busy          <= busy_next;
			ok            <= ok_next;
			err           <= err_next;
		end
	end

endmodule

/* logic/ps2_frame_shift.sv */
// PS/2 frame builder and shifter

`timescale 1ns/10ps

module ps2_frame_shift (
	input  logic                qzt_clk,
	input  logic                reset,
	input  logic                frame_load,
	input  ps2_pkg::ps2_byte_t  frame_byte,
	input  logic                frame_shift,
	output logic                bit_out,
	output logic                last_bit
);

	// frame captured on load
	ps2_pkg::ps2_frame_t frame;

	// position of the bit on the line, 0 is the start bit
	logic [3:0] bit_idx;

	// parity bit that makes the count of ones over data and parity odd
	logic parity;

	assign parity = ~(^frame_byte);

	//////////////////////////////////////////////////
	// frame register, payload only
	//////////////////////////////////////////////////

	always_ff @(posedge qzt_clk) begin
		if (frame_load) begin
			// stop, parity, byte lsb first, start
			frame <= {1'b1, parity, frame_byte, 1'b0};
		end
	end

	//////////////////////////////////////////////////
	// bit index
	//////////////////////////////////////////////////

	always_ff @(posedge qzt_clk) begin
		if (reset) begin
			bit_idx <= '0;
		end else if (frame_load) begin
			// start bit comes first
			bit_idx <= '0;
		end else if (frame_shift && !last_bit) begin
			bit_idx <= bit_idx + 4'd1;
		end
	end

	assign bit_out = frame[bit_idx];

	// stop bit sits at the top of the frame
	assign last_bit = (bit_idx == 4'(ps2_pkg::FRAME_BITS - 1));

endmodule

/* logic/ps2_line_sync.sv */
// PS/2 line synchronizer

`timescale 1ns/10ps

module ps2_line_sync (
	input  logic qzt_clk,
	input  logic reset,
	input  logic ps2_clk_in,
	input  logic ps2_data_in,
	output logic clk_level,
	output logic data_level,
	output logic clk_fall,
	output logic clk_rise
);

	// first stage of each synchronizer
	logic clk_meta;
	logic data_meta;

	// clock level one cycle older, for edge detection
	logic clk_prev;

	// two flops per line, idle level is high (released)
	always_ff @(posedge qzt_clk) begin
		if (reset) begin
			clk_meta   <= 1'b1;
			clk_level  <= 1'b1;
			data_meta  <= 1'b1;
			data_level <= 1'b1;
			clk_prev   <= 1'b1;
		end else begin
			clk_meta   <= ps2_clk_in;
			clk_level  <= clk_meta;
			data_meta  <= ps2_data_in;
			data_level <= data_meta;
			clk_prev   <= clk_level;
		end
	end

	// single cycle strobes, aligned with the synced level change
	assign clk_fall = clk_prev & ~clk_level;
	assign clk_rise = ~clk_prev & clk_level;

endmodule

/* logic/ps2_us_timer.sv */
// One-shot microsecond timer

`timescale 1ns/10ps

module ps2_us_timer (
	input  logic                qzt_clk,
	input  logic                reset,
	input  logic                timer_start,
	input  logic                timer_cancel,
	input  ps2_pkg::us_count_t  timer_us,
	output logic                timer_done
);

	// cycle prescaler, wraps once per microsecond
	ps2_pkg::cyc_count_t presc;

	// microseconds still to go, counted down on each tick
	ps2_pkg::us_count_t us_left;

	// high while a delay is pending
	logic running;

	// last cycle of the current microsecond
	logic us_tick;

	// tick when the prescaler sits on its final count
	assign us_tick = running && (presc == ps2_pkg::CYCLES_PER_US - 8'd1);

	// done lands exactly timer_us * CYCLES_PER_US cycles after start
	// a zero length request finishes after a single microsecond
	assign timer_done = us_tick && (us_left <= ps2_pkg::us_count_t'(1));

	//////////////////////////////////////////////////
	// counters
	//////////////////////////////////////////////////

	always_ff @(posedge qzt_clk) begin
		if (reset) begin
			running <= 1'b0;
			presc   <= '0;
			us_left <= '0;
		end else if (timer_start) begin
			// restart from scratch, prescaler cleared so the delay is exact
			running <= 1'b1;
			presc   <= '0;
			us_left <= timer_us;
		end else if (timer_cancel) begin
			// drop whatever was pending
			running <= 1'b0;
			presc   <= '0;
		end else if (running) begin
			if (us_tick) begin
				presc <= '0;
				if (timer_done) begin
					// one pulse only, then idle until the next start
					running <= 1'b0;
				end else begin
					us_left <= us_left - ps2_pkg::us_count_t'(1);
				end
			end else begin
				presc <= presc + 8'd1;
			end
		end
	end

endmodule

/* logic/ps2_pkg.sv */
// PS/2 host transmitter definitions

package ps2_pkg;

	//////////////////////////////////////////////////
	// vector types
	//////////////////////////////////////////////////

	// one command byte as the user hands it in
	typedef logic [7:0] ps2_byte_t;

	// full frame on the wire
	// bit 0 start, bits 1..8 data lsb first, bit 9 odd parity, bit 10 stop
	typedef logic [10:0] ps2_frame_t;

	// durations in microseconds, wide enough for the device timeout
	typedef logic [11:0] us_count_t;

	// qzt_clk cycles inside one microsecond
	typedef logic [7:0] cyc_count_t;

	//////////////////////////////////////////////////
	// transmit state machine
	//////////////////////////////////////////////////

	typedef enum logic [3:0] {
		// waiting for a rising edge on send
		IDLE,
		// clock held low, data still released
		INHIBIT_CLK,
		// clock and data both low (request to send)
		INHIBIT_DATA,
		// device clocks, host puts the next bit out on each fall
		WAIT_FALL,
		// stop bit is on the line, wait for the device to read it
		WAIT_LAST_RISE,
		// short hold before data is let go
		HOLD_LAST,
		// device drives the acknowledge bit
		WAIT_ACK,
		// quiet time after the acknowledge
		END_PACKET,
		// both lines must stay high for a while
		WAIT_RELEASE
	} tx_state_t;

	//////////////////////////////////////////////////
	// protocol timing
	//////////////////////////////////////////////////

	// 4 ns clock, so 250 cycles per microsecond
	localparam cyc_count_t CYCLES_PER_US = 8'd250;

	// clock low before data low, and data low before clock release
	localparam us_count_t INHIBIT_US = 12'd60;

	// hold after the rising edge that reads the stop bit
	localparam us_count_t LAST_HOLD_US = 12'd3;

	// quiet wait once the acknowledge is in
	localparam us_count_t END_PACKET_US = 12'd60;

	// both lines high at least this long before ok
	localparam us_count_t RELEASE_US = 12'd20;

	// longest wait for any expected device clock edge
	localparam us_count_t DEVICE_TIMEOUT_US = 12'd2000;

	// bits in one host to device frame
	localparam int unsigned FRAME_BITS = 11;

endpackage
